//--- dcache_top.f
+incdir+hw
hw/dcache_pkg.sv
hw/dcache_way_sram.sv
hw/dcache_writeback.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
tests/dcache_mem_model.sv
tests/dcache_props.sv
tests/dcache_tb.sv

//--- tests/dcache_tb.sv
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_tb;
    import dcache_pkg::*;

    localparam int          RESET_CYCLES = 10;
    localparam int          PASS_LEN     = 11;
    localparam int          NUM          = 2 * PASS_LEN;
    localparam int          LIMIT        = NUM * 300 + RESET_CYCLES;
    // second pass moves to other sets and tags
    localparam logic [31:0] PASS2_OFS    = 32'h0010_0100;

    logic                  I_clk = 1'b0;
    logic                  I_rst;
    logic [`DC_ADDR_W-1:0] cpu_addr;
    logic [63:0]           cpu_wdata;
    logic [7:0]            cpu_wmask;
    logic                  cpu_rd_req;
    logic                  cpu_wr_req;
    logic                  cpu_ready;
    logic [63:0]           cpu_rdata;
    logic                  cpu_rvalid;
    logic                  cpu_bvalid;
    logic [31:0]           mem_araddr;
    logic                  mem_arvalid;
    logic                  mem_arready;
    logic [63:0]           mem_rdata;
    logic                  mem_rvalid;
    logic                  mem_rlast;
    logic [31:0]           mem_awaddr;
    logic                  mem_awvalid;
    logic                  mem_awready;
    logic [63:0]           mem_wdata;
    logic                  mem_wvalid;
    logic                  mem_wlast;
    logic                  mem_wready;
    logic                  mem_bvalid;
    logic                  stall_en;

    // stimulus table
    cpu_op_e     t_op    [NUM];
    logic [31:0] t_addr  [NUM];
    logic [63:0] t_wdata [NUM];
    logic [7:0]  t_mask  [NUM];
    logic [63:0] t_exp   [NUM];
    logic        t_hit   [NUM];
    logic [31:0] t_wb    [NUM];
    int          n_entries = 0;

    // cpu view of memory after all table writes
    logic [63:0] shadow [logic [31:0]];

    int          cycles = 0;
    int          errors = 0;
    int          passed = 0;
    int          failed = 0;
    int          ar_count = 0;
    int          aw_count = 0;
    int          beat_count = 0;
    logic [31:0] ar_addr;
    logic [31:0] aw_addr;

    always #4 I_clk = ~I_clk;

    dcache_top UUT (.*);

    dcache_mem_model mem (.*);

    bind dcache_top dcache_props props (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_bvalid  (cpu_bvalid),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wvalid  (mem_wvalid),
        .mem_wlast   (mem_wlast),
        .state       (ctrl.state)
    );

    function automatic logic [63:0] view_word(logic [31:0] a);
        logic [31:0] a8;
        a8 = {a[31:3], 3'b000};
        if (shadow.exists(a8)) begin
            return shadow[a8];
        end
        // untouched memory reads as the address over its inverse
        return {a8, ~a8};
    endfunction

    task automatic add_entry(cpu_op_e op, logic [31:0] addr, logic [63:0] wdata,
                             logic [7:0] mask, logic hit, logic [31:0] wb);
        logic [63:0] w;
        w = view_word(addr);
        for (int b = 0; b < 8; b++) begin
            if (mask[b]) begin
                w[b * 8 +: 8] = wdata[b * 8 +: 8];
            end
        end
        if (op == OP_WRITE) begin
            shadow[{addr[31:3], 3'b000}] = w;
        end
        t_op[n_entries]    = op;
        t_addr[n_entries]  = addr;
        t_wdata[n_entries] = wdata;
        t_mask[n_entries]  = mask;
        t_exp[n_entries]   = w;
        t_hit[n_entries]   = hit;
        t_wb[n_entries]    = wb;
        n_entries++;
    endtask

    task automatic build_pass(logic [31:0] ofs);
        add_entry(OP_READ,  32'h1048 + ofs, '0, 8'h00, 1'b0, '0);
        add_entry(OP_READ,  32'h1048 + ofs, '0, 8'h00, 1'b1, '0);
        add_entry(OP_WRITE, 32'h1048 + ofs, 64'h1122334455667788, 8'h0f, 1'b1, '0);
        add_entry(OP_READ,  32'h1048 + ofs, '0, 8'h00, 1'b1, '0);
        add_entry(OP_WRITE, 32'h2070 + ofs, 64'haabbccddeeff0011, 8'hf0, 1'b0, '0);
        add_entry(OP_READ,  32'h2070 + ofs, '0, 8'h00, 1'b1, '0);
        // three lines into one set in the order A B C
        add_entry(OP_READ,  32'h40a8 + ofs, '0, 8'h00, 1'b0, '0);
        add_entry(OP_WRITE, 32'h40a8 + ofs, 64'hdeadbeefcafef00d, 8'hff, 1'b1, '0);
        add_entry(OP_WRITE, 32'h48a0 + ofs, 64'h0000000000001234, 8'h03, 1'b0, '0);
        add_entry(OP_READ,  32'h50b0 + ofs, '0, 8'h00, 1'b0, 32'h40a0 + ofs);
        add_entry(OP_READ,  32'h40a8 + ofs, '0, 8'h00, 1'b0, '0);
    endtask

    task automatic check_data(string name, logic [63:0] exp, logic [63:0] got);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_line_beat(logic [31:0] addr, logic [63:0] exp, logic [63:0] got);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t mem_wdata @%h expected %h got %h", $time, addr, exp, got);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic got);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %b got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_state(ctrl_state_e exp, ctrl_state_e got);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t state expected %s got %s", $time, exp.name(), got.name());
        end
    endtask

    ////////////////////////////////
    // bus monitor and timeout
    ////////////////////////////////
    always @(posedge I_clk) begin
        cycles++;
        if (mem_arvalid && mem_arready) begin
            ar_count++;
            ar_addr = mem_araddr;
        end
        if (mem_awvalid && mem_awready) begin
            aw_count++;
            aw_addr    = mem_awaddr;
            beat_count = 0;
        end
        if (mem_wvalid && mem_wready) begin
            check_line_beat(aw_addr + 32'(8 * beat_count),
                            view_word(aw_addr + 32'(8 * beat_count)), mem_wdata);
            check_flag("mem_wlast", (beat_count == `DC_BEATS - 1), mem_wlast);
            beat_count++;
        end
        if (cycles >= LIMIT) begin
            $display("ERROR: timeout after %0d cycles, the cache stopped answering", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic run_entry(int i);
        int          ar0;
        int          aw0;
        int          err0;
        int          acc;
        logic [63:0] got;
        logic        done;
        ar0        = ar_count;
        aw0        = aw_count;
        err0       = errors;
        done       = 1'b0;
        cpu_addr   = t_addr[i];
        cpu_wdata  = t_wdata[i];
        cpu_wmask  = t_mask[i];
        cpu_rd_req = (t_op[i] == OP_READ);
        cpu_wr_req = (t_op[i] == OP_WRITE);
        @(posedge I_clk);
        while (!cpu_ready) @(posedge I_clk);
        #1;
        acc        = cycles;
        cpu_rd_req = 1'b0;
        cpu_wr_req = 1'b0;
        while (!done) begin
            @(posedge I_clk);
            if ((t_op[i] == OP_READ) ? cpu_rvalid : cpu_bvalid) begin
                done = 1'b1;
                got  = cpu_rdata;
            end
        end
        #1;
        if (t_op[i] == OP_READ) begin
            check_data("cpu_rdata", t_exp[i], got);
        end
        if (t_hit[i]) begin
            if (cycles - acc != 1) begin
                errors++;
                $display("entry %0d: hit answered after %0d cycles, not 1", i, cycles - acc);
            end
            if (ar_count != ar0) begin
                errors++;
                $display("entry %0d: hit went out on the bus", i);
            end
        end else if (ar_count != ar0 + 1) begin
            errors++;
            $display("entry %0d: miss made %0d bus reads instead of one", i, ar_count - ar0);
        end else begin
            check_data("mem_araddr", {32'h0, t_addr[i] & ~32'h1f}, {32'h0, ar_addr});
        end
        if (t_wb[i] != '0) begin
            if (aw_count != aw0 + 1 || beat_count != `DC_BEATS) begin
                errors++;
                $display("entry %0d: dirty victim was not written back in full", i);
            end else begin
                check_data("mem_awaddr", {32'h0, t_wb[i]}, {32'h0, aw_addr});
            end
        end else if (aw_count != aw0) begin
            errors++;
            $display("entry %0d: write-back where none was due", i);
        end
        if (errors == err0) begin
            passed++;
            $display("entry %0d %s %h ok", i, t_op[i].name(), t_addr[i]);
        end else begin
            failed++;
            $display("entry %0d %s %h failed", i, t_op[i].name(), t_addr[i]);
        end
    endtask

    initial begin
        void'($urandom(32'h7abe));
        I_rst      = 1'b1;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_wmask  = '0;
        cpu_rd_req = 1'b0;
        cpu_wr_req = 1'b0;
        stall_en   = 1'b0;
        build_pass(32'h0);
        build_pass(PASS2_OFS);

        repeat (RESET_CYCLES) @(posedge I_clk);
        #1;
        I_rst = 1'b0;
        check_state(IDLE, UUT.ctrl.state);
        check_flag("cpu_ready", 1'b1, cpu_ready);
        check_flag("cpu_rvalid", 1'b0, cpu_rvalid);
        check_flag("cpu_bvalid", 1'b0, cpu_bvalid);
        check_flag("mem_arvalid", 1'b0, mem_arvalid);
        check_flag("mem_awvalid", 1'b0, mem_awvalid);
        check_flag("mem_wvalid", 1'b0, mem_wvalid);
        $display("reset check done, %0d errors", errors);

        for (int i = 0; i < PASS_LEN; i++) begin
            run_entry(i);
        end
        // same sequence again under bus back-pressure
        stall_en = 1'b1;
        for (int i = PASS_LEN; i < n_entries; i++) begin
            run_entry(i);
        end

        @(posedge I_clk);
        #1;
        $display("%0d entries passed, %0d failed, %0d errors, %0d assertion failures",
                 passed, failed, errors, UUT.props.fails);
        if (failed == 0 && errors == 0 && UUT.props.fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tests/dcache_props.sv
`timescale 1ns/100ps

module dcache_props (
    input logic                    I_clk,
    input logic                    I_rst,
    input logic                    cpu_rvalid,
    input logic                    cpu_bvalid,
    input logic                    mem_arvalid,
    input logic                    mem_arready,
    input logic                    mem_awvalid,
    input logic                    mem_awready,
    input logic                    mem_wvalid,
    input logic                    mem_wlast,
    input dcache_pkg::ctrl_state_e state
);
    import dcache_pkg::*;

    // failure count, read back by the testbench
    int fails = 0;

    ar_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_arvalid && !mem_arready |=> mem_arvalid)
        else begin
            $error("mem_arvalid dropped before mem_arready");
            fails++;
        end

    aw_hold: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_awvalid && !mem_awready |=> mem_awvalid)
        else begin
            $error("mem_awvalid dropped before mem_awready");
            fails++;
        end

    wlast_in_beat: assert property (@(posedge I_clk) disable iff (I_rst)
        mem_wlast |-> mem_wvalid)
        else begin
            $error("mem_wlast high without mem_wvalid");
            fails++;
        end

    one_response: assert property (@(posedge I_clk) disable iff (I_rst)
        !(cpu_rvalid && cpu_bvalid))
        else begin
            $error("cpu_rvalid and cpu_bvalid high together");
            fails++;
        end

    // first cycle out of reset
    quiet_after_reset: assert property (@(posedge I_clk)
        $fell(I_rst) |-> !cpu_rvalid && !cpu_bvalid && !mem_arvalid && !mem_awvalid
                         && !mem_wvalid && state == IDLE)
        else begin
            $error("valid output high right after reset");
            fails++;
        end

endmodule

//--- tests/dcache_mem_model.sv
`timescale 1ns/100ps

module dcache_mem_model (
    input  logic        I_clk,
    input  logic        stall_en,
    input  logic [31:0] mem_araddr,
    input  logic        mem_arvalid,
    output logic        mem_arready,
    output logic [63:0] mem_rdata,
    output logic        mem_rvalid,
    output logic        mem_rlast,
    input  logic [31:0] mem_awaddr,
    input  logic        mem_awvalid,
    output logic        mem_awready,
    input  logic [63:0] mem_wdata,
    input  logic        mem_wvalid,
    output logic        mem_wready,
    output logic        mem_bvalid
);
    // every beat written so far by 8-byte address
    logic [63:0] written [logic [31:0]];

    function automatic logic [63:0] read_word(logic [31:0] a);
        if (written.exists(a)) begin
            return written[a];
        end
        return {a, ~a};
    endfunction

    // random idle cycles when stalls are on
    task automatic random_stall();
        int n;
        n = stall_en ? $urandom_range(3, 0) : 0;
        repeat (n) begin
            @(posedge I_clk);
            #1;
        end
    endtask

    ////////////////////////////////
    // read channel
    ////////////////////////////////
    initial begin : read_channel
        logic [31:0] base;
        mem_arready = 1'b0;
        mem_rvalid  = 1'b0;
        mem_rlast   = 1'b0;
        mem_rdata   = '0;
        forever begin
            @(posedge I_clk);
            while (mem_arvalid !== 1'b1) @(posedge I_clk);
            #1;
            random_stall();
            mem_arready = 1'b1;
            @(posedge I_clk);
            base = mem_araddr;
            #1;
            mem_arready = 1'b0;
            for (int k = 0; k < 4; k++) begin
                random_stall();
                mem_rvalid = 1'b1;
                mem_rdata  = read_word(base + 32'(8 * k));
                mem_rlast  = (k == 3);
                @(posedge I_clk);
                #1;
                mem_rvalid = 1'b0;
                mem_rlast  = 1'b0;
            end
        end
    end

    ////////////////////////////////
    // write channel
    ////////////////////////////////
    initial begin : write_channel
        logic [31:0] base;
        mem_awready = 1'b0;
        mem_wready  = 1'b0;
        mem_bvalid  = 1'b0;
        forever begin
            @(posedge I_clk);
            while (mem_awvalid !== 1'b1) @(posedge I_clk);
            #1;
            random_stall();
            mem_awready = 1'b1;
            @(posedge I_clk);
            base = mem_awaddr;
            #1;
            mem_awready = 1'b0;
            for (int k = 0; k < 4; k++) begin
                random_stall();
                mem_wready = 1'b1;
                do begin
                    @(posedge I_clk);
                end while (!mem_wvalid);
                written[base + 32'(8 * k)] = mem_wdata;
                #1;
                mem_wready = 1'b0;
            end
            random_stall();
            mem_bvalid = 1'b1;
            @(posedge I_clk);
            #1;
            mem_bvalid = 1'b0;
        end
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                  I_clk,
    input  logic                  I_rst,
    // cpu port
    input  logic [`DC_ADDR_W-1:0] cpu_addr,
    input  logic [63:0]           cpu_wdata,
    input  logic [7:0]            cpu_wmask,
    input  logic                  cpu_rd_req,
    input  logic                  cpu_wr_req,
    output logic                  cpu_ready,
    output logic [63:0]           cpu_rdata,
    output logic                  cpu_rvalid,
    output logic                  cpu_bvalid,
    // bus read channel
    output logic [`DC_ADDR_W-1:0] mem_araddr,
    output logic                  mem_arvalid,
    input  logic                  mem_arready,
    input  logic [63:0]           mem_rdata,
    input  logic                  mem_rvalid,
    input  logic                  mem_rlast,
    // bus write channel
    output logic [`DC_ADDR_W-1:0] mem_awaddr,
    output logic                  mem_awvalid,
    input  logic                  mem_awready,
    output logic [63:0]           mem_wdata,
    output logic                  mem_wvalid,
    output logic                  mem_wlast,
    input  logic                  mem_wready,
    input  logic                  mem_bvalid
);
    import dcache_pkg::*;

    line_t                  way0_rdata;
    line_t                  way1_rdata;
    line_t                  sram_wdata;
    line_t                  sram_wmask;
    logic [`DC_INDEX_W-1:0] sram_addr;
    logic [1:0]             sram_cen;
    logic [1:0]             sram_wen;
    logic                   wb_start;
    logic [`DC_ADDR_W-1:0]  wb_addr;
    line_t                  wb_line;
    logic                   wb_done;

    dcache_ctrl ctrl (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .cpu_addr    (cpu_addr),
        .cpu_wdata   (cpu_wdata),
        .cpu_wmask   (cpu_wmask),
        .cpu_rd_req  (cpu_rd_req),
        .cpu_wr_req  (cpu_wr_req),
        .cpu_ready   (cpu_ready),
        .cpu_rvalid  (cpu_rvalid),
        .cpu_bvalid  (cpu_bvalid),
        .cpu_rdata   (cpu_rdata),
        .way0_rdata  (way0_rdata),
        .way1_rdata  (way1_rdata),
        .sram_addr   (sram_addr),
        .sram_cen    (sram_cen),
        .sram_wen    (sram_wen),
        .sram_wdata  (sram_wdata),
        .sram_wmask  (sram_wmask),
        .mem_araddr  (mem_araddr),
        .mem_arvalid (mem_arvalid),
        .mem_arready (mem_arready),
        .mem_rvalid  (mem_rvalid),
        .mem_rlast   (mem_rlast),
        .mem_rdata   (mem_rdata),
        .wb_start    (wb_start),
        .wb_addr     (wb_addr),
        .wb_line     (wb_line),
        .wb_done     (wb_done)
    );

    dcache_way_sram way0 (
        .I_clk (I_clk),
        .cen   (sram_cen[0]),
        .wen   (sram_wen[0]),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .wmask (sram_wmask),
        .rdata (way0_rdata)
    );

    dcache_way_sram way1 (
        .I_clk (I_clk),
        .cen   (sram_cen[1]),
        .wen   (sram_wen[1]),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .wmask (sram_wmask),
        .rdata (way1_rdata)
    );

    dcache_writeback wb (
        .I_clk       (I_clk),
        .I_rst       (I_rst),
        .wb_start    (wb_start),
        .wb_addr     (wb_addr),
        .wb_line     (wb_line),
        .wb_done     (wb_done),
        .mem_awaddr  (mem_awaddr),
        .mem_awvalid (mem_awvalid),
        .mem_awready (mem_awready),
        .mem_wdata   (mem_wdata),
        .mem_wvalid  (mem_wvalid),
        .mem_wlast   (mem_wlast),
        .mem_wready  (mem_wready),
        .mem_bvalid  (mem_bvalid)
    );

endmodule

//--- hw/dcache_ctrl.sv
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_ctrl (
    input  logic                   I_clk,
    input  logic                   I_rst,
    // cpu port
    input  logic [`DC_ADDR_W-1:0]  cpu_addr,
    input  logic [63:0]            cpu_wdata,
    input  logic [7:0]             cpu_wmask,
    input  logic                   cpu_rd_req,
    input  logic                   cpu_wr_req,
    output logic                   cpu_ready,
    output logic                   cpu_rvalid,
    output logic                   cpu_bvalid,
    output logic [63:0]            cpu_rdata,
    // way arrays, enables active low
    input  dcache_pkg::line_t      way0_rdata,
    input  dcache_pkg::line_t      way1_rdata,
    output logic [`DC_INDEX_W-1:0] sram_addr,
    output logic [1:0]             sram_cen,
    output logic [1:0]             sram_wen,
    output dcache_pkg::line_t      sram_wdata,
    output dcache_pkg::line_t      sram_wmask,
    // bus read channel
    output logic [`DC_ADDR_W-1:0]  mem_araddr,
    output logic                   mem_arvalid,
    input  logic                   mem_arready,
    input  logic                   mem_rvalid,
    input  logic                   mem_rlast,
    input  logic [63:0]            mem_rdata,
    // write-back engine
    output logic                   wb_start,
    output logic [`DC_ADDR_W-1:0]  wb_addr,
    output dcache_pkg::line_t      wb_line,
    input  logic                   wb_done
);
    import dcache_pkg::*;

    localparam int SEL_W = `DC_OFFSET_W - 3;

    ctrl_state_e             state;
    ctrl_state_e             next_state;
    cpu_op_e                 op;

    logic [`DC_TAG_W-1:0]    tag;
    logic [`DC_INDEX_W-1:0]  index;
    logic [`DC_OFFSET_W-1:0] offset;
    logic [`DC_ADDR_W-1:0]   req_addr;
    logic [`DC_TAG_W-1:0]    req_tag;
    logic [`DC_INDEX_W-1:0]  req_index;
    logic [`DC_OFFSET_W-1:0] req_offset;
    logic [SEL_W-1:0]        req_sel;
    logic [63:0]             st_data;
    logic [7:0]              st_mask;

    logic [`DC_TAG_W-1:0]    tag_tab [0:1][0:`DC_SETS-1];
    logic [1:0][`DC_SETS-1:0] valid_tab;
    logic [1:0][`DC_SETS-1:0] dirty_tab;

    logic                    way0_hit;
    logic                    way1_hit;
    logic                    hit;
    logic                    victim_way;
    // way the current request works on
    logic                    way_q;
    logic                    accept;
    logic                    fill_last;
    logic                    victim_dirty;
    logic                    wb_kick;

    line_t                   line_buf;
    line_t                   merged_line;
    line_t                   hit_wmask;
    line_t                   hit_line;

    //////////////////////////////
    // lookup
    //////////////////////////////

    assign {tag, index, offset} = cpu_addr;
    assign {req_tag, req_index, req_offset} = req_addr;
    assign req_sel = req_offset[`DC_OFFSET_W-1:3];

    always_comb begin
        op = OP_NONE;
        if (cpu_rd_req && !cpu_wr_req) begin
            op = OP_READ;
        end else if (cpu_wr_req && !cpu_rd_req) begin
            op = OP_WRITE;
        end
    end

    assign way0_hit = valid_tab[0][index] && (tag_tab[0][index] == tag);
    assign way1_hit = valid_tab[1][index] && (tag_tab[1][index] == tag);
    assign hit      = way0_hit || way1_hit;

    // hit way, else way 1 if only way 0 is taken, else way 0
    assign victim_way = way1_hit || (!hit && valid_tab[0][index] && !valid_tab[1][index]);

    assign cpu_ready = (state == IDLE) || (state == RD_HIT) || (state == WR_HIT);
    assign accept    = cpu_ready && (op != OP_NONE);

    always_ff @(posedge I_clk) begin
        if (accept) begin
            req_addr <= cpu_addr;
            st_data  <= cpu_wdata;
            st_mask  <= cpu_wmask;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            way_q <= 1'b0;
        end else if (accept) begin
            way_q <= victim_way;
        end
    end

    //////////////////////////////
    // fill and victim
    //////////////////////////////

    assign mem_arvalid = (state == RD_MISS) || (state == WR_MISS);
    assign mem_araddr  = {req_tag, req_index, {`DC_OFFSET_W{1'b0}}};
    assign fill_last   = ((state == RD_RELOAD) || (state == WR_RELOAD)) && mem_rvalid && mem_rlast;
    assign victim_dirty = dirty_tab[way_q][req_index];

    // first beat ends up lowest
    always_ff @(posedge I_clk) begin
        if (((state == RD_RELOAD) || (state == WR_RELOAD)) && mem_rvalid) begin
            line_buf <= {mem_rdata, line_buf[`DC_LINE_W-1:64]};
        end
    end

    // pending store goes into the filled line
    always_comb begin
        merged_line = line_buf;
        if (state == WR_ALLOCATE) begin
            for (int b = 0; b < 8; b++) begin
                if (st_mask[b]) begin
                    merged_line[req_sel * 64 + b * 8 +: 8] = st_data[b * 8 +: 8];
                end
            end
        end
    end

    // victim read issued on the last beat, data is there one cycle later
    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            wb_kick <= 1'b0;
        end else begin
            wb_kick <= fill_last && victim_dirty;
        end
    end

    assign hit_line = way_q ? way1_rdata : way0_rdata;
    assign wb_start = wb_kick;
    assign wb_line  = hit_line;
    assign wb_addr  = {tag_tab[way_q][req_index], req_index, {`DC_OFFSET_W{1'b0}}};

    //////////////////////////////
    // cpu response
    //////////////////////////////

    assign cpu_rvalid = (state == RD_HIT) || (state == RD_ALLOCATE);
    assign cpu_bvalid = (state == WR_HIT);
    assign cpu_rdata  = (state == RD_ALLOCATE) ? line_buf[req_sel * 64 +: 64]
                                               : hit_line[req_sel * 64 +: 64];

    //////////////////////////////
    // array control
    //////////////////////////////

    // bytes of the addressed beat cleared in the mask
    always_comb begin
        hit_wmask = '1;
        for (int b = 0; b < 8; b++) begin
            if (cpu_wmask[b]) begin
                hit_wmask[offset[`DC_OFFSET_W-1:3] * 64 + b * 8 +: 8] = 8'h00;
            end
        end
    end

    // store lands as it is accepted, so the next read sees it
    always_comb begin
        sram_cen   = 2'b11;
        sram_wen   = 2'b11;
        sram_addr  = req_index;
        sram_wdata = merged_line;
        sram_wmask = '0;
        if (accept && hit) begin
            sram_cen[way1_hit] = 1'b0;
            sram_addr = index;
            if (op == OP_WRITE) begin
                sram_wen[way1_hit] = 1'b0;
                sram_wdata = {`DC_BEATS{cpu_wdata}};
                sram_wmask = hit_wmask;
            end
        end else if (fill_last && victim_dirty) begin
            sram_cen[way_q] = 1'b0;
        end else if ((state == RD_ALLOCATE) || (state == WR_ALLOCATE)) begin
            sram_cen[way_q] = 1'b0;
            sram_wen[way_q] = 1'b0;
        end
    end

    //////////////////////////////
    // tag, valid and dirty tables
    //////////////////////////////

    always_ff @(posedge I_clk) begin
        if ((state == RD_ALLOCATE) || (state == WR_ALLOCATE)) begin
            tag_tab[way_q][req_index] <= req_tag;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            valid_tab <= '0;
            dirty_tab <= '0;
        end else begin
            if (accept && hit && (op == OP_WRITE)) begin
                dirty_tab[way1_hit][index] <= 1'b1;
            end
            if (wb_done) begin
                dirty_tab[way_q][req_index] <= 1'b0;
            end
            if ((state == RD_ALLOCATE) || (state == WR_ALLOCATE)) begin
                valid_tab[way_q][req_index] <= 1'b1;
                dirty_tab[way_q][req_index] <= (state == WR_ALLOCATE);
            end
        end
    end

    //////////////////////////////
    // main FSM
    //////////////////////////////

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE, RD_HIT, WR_HIT: begin
                case (op)
                    OP_READ:  next_state = hit ? RD_HIT : RD_MISS;
                    OP_WRITE: next_state = hit ? WR_HIT : WR_MISS;
                    default:  next_state = IDLE;
                endcase
            end
            RD_MISS:     next_state = mem_arready ? RD_RELOAD : RD_MISS;
            WR_MISS:     next_state = mem_arready ? WR_RELOAD : WR_MISS;
            RD_RELOAD: begin
                if (fill_last) begin
                    next_state = victim_dirty ? RD_WB : RD_ALLOCATE;
                end
            end
            WR_RELOAD: begin
                if (fill_last) begin
                    next_state = victim_dirty ? WR_WB : WR_ALLOCATE;
                end
            end
            RD_WB:       next_state = wb_done ? RD_ALLOCATE : RD_WB;
            WR_WB:       next_state = wb_done ? WR_ALLOCATE : WR_WB;
            RD_ALLOCATE: next_state = IDLE;
            // write response comes out of WR_HIT
            WR_ALLOCATE: next_state = WR_HIT;
            default:     next_state = IDLE;
        endcase
    end

endmodule

//--- hw/dcache_writeback.sv
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_writeback (
    input  logic                  I_clk,
    input  logic                  I_rst,
    input  logic                  wb_start,
    input  logic [`DC_ADDR_W-1:0] wb_addr,
    input  dcache_pkg::line_t     wb_line,
    output logic                  wb_done,
    output logic [`DC_ADDR_W-1:0] mem_awaddr,
    output logic                  mem_awvalid,
    input  logic                  mem_awready,
    output logic [63:0]           mem_wdata,
    output logic                  mem_wvalid,
    output logic                  mem_wlast,
    input  logic                  mem_wready,
    input  logic                  mem_bvalid
);
    import dcache_pkg::*;

    localparam int BEAT_W = $clog2(`DC_BEATS);

    wb_state_e             state;
    line_t                 line_q;
    logic [`DC_ADDR_W-1:0] addr_q;
    logic [BEAT_W-1:0]     beat;
    // only the response is left after the last beat
    logic                  resp_wait;
    logic                  w_fire;

    assign mem_awaddr  = addr_q;
    assign mem_awvalid = (state == WB_ADDR);
    assign mem_wvalid  = (state == WB_DATA) && !resp_wait;
    assign mem_wdata   = line_q[beat * 64 +: 64];
    assign mem_wlast   = (state == WB_DATA) && (beat == BEAT_W'(`DC_BEATS - 1));
    assign w_fire      = mem_wvalid && mem_wready;
    assign wb_done     = (state == WB_DATA) && resp_wait && mem_bvalid;

    // victim capture
    always_ff @(posedge I_clk) begin
        if (state == WB_IDLE && wb_start) begin
            line_q <= wb_line;
            addr_q <= wb_addr;
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rst) begin
            state     <= WB_IDLE;
            beat      <= '0;
            resp_wait <= 1'b0;
        end else begin
            case (state)
                WB_IDLE: begin
                    if (wb_start) begin
                        state <= WB_ADDR;
                        beat  <= '0;
                    end
                end
                WB_ADDR: begin
                    if (mem_awready) begin
                        state <= WB_DATA;
                    end
                end
                WB_DATA: begin
                    if (w_fire) begin
                        beat <= beat + 1'b1;
                        if (mem_wlast) begin
                            resp_wait <= 1'b1;
                        end
                    end else if (wb_done) begin
                        state     <= WB_IDLE;
                        resp_wait <= 1'b0;
                    end
                end
                default: state <= WB_IDLE;
            endcase
        end
    end

endmodule

//--- hw/dcache_way_sram.sv
`timescale 1ns/100ps
`include "dcache_defines.svh"

module dcache_way_sram (
    input  logic                   I_clk,
    input  logic                   cen,
    input  logic                   wen,
    input  logic [`DC_INDEX_W-1:0] addr,
    input  dcache_pkg::line_t      wdata,
    input  dcache_pkg::line_t      wmask,
    output dcache_pkg::line_t      rdata
);
    import dcache_pkg::*;

    line_t mem [0:`DC_SETS-1];

    // masked write, a zero mask bit lets that bit through
    always_ff @(posedge I_clk) begin
        if (!cen && !wen) begin
            mem[addr] <= (mem[addr] & wmask) | (wdata & ~wmask);
        end
    end

    // registered read, data one cycle after cen
    always_ff @(posedge I_clk) begin
        if (!cen && wen) begin
            rdata <= mem[addr];
        end
    end

endmodule

//--- hw/dcache_pkg.sv
`include "dcache_defines.svh"

package dcache_pkg;

    // one full cache line
    typedef logic [`DC_LINE_W-1:0] line_t;

    // main controller FSM
    typedef enum logic [3:0] {
        IDLE,
        RD_HIT,
        WR_HIT,
        RD_MISS,
        WR_MISS,
        RD_RELOAD,
        WR_RELOAD,
        RD_WB,
        WR_WB,
        RD_ALLOCATE,
        WR_ALLOCATE
    } ctrl_state_e;

    // victim write-back sequencer
    typedef enum logic [1:0] {
        WB_IDLE,
        WB_ADDR,
        WB_DATA
    } wb_state_e;

    // decoded cpu request
    typedef enum logic [1:0] {
        OP_NONE,
        OP_READ,
        OP_WRITE
    } cpu_op_e;

endpackage

//--- hw/dcache_defines.svh
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// address split, tag | index | offset
`define DC_ADDR_W   32
`define DC_OFFSET_W 5
`define DC_INDEX_W  6
`define DC_TAG_W    21

// 64 sets of two ways
`define DC_SETS     (1 << `DC_INDEX_W)

// line fill and write-back burst, 8 bytes per beat
`define DC_BEATS    4
`define DC_LINE_W   256

`endif
